// File: filelist.f
+incdir+rtl
rtl/ppe_pkg.sv
rtl/hdr_dispatch.sv
rtl/ppe_lane.sv
rtl/result_merge.sv
rtl/rx_ppe_top.sv
sim/tb_rx_ppe.sv

// File: rtl/hdr_dispatch.sv
// header dispatcher: input queue, per-lane credit counters, round-robin issue
`timescale 1ns/1ps
`include "ppe_config.svh"

module hdr_dispatch (
  input  logic               cclk,
  input  logic               rst,
  input  ppe_pkg::ppe_hdr_t  hdr_in,
  input  ppe_pkg::lane_vec_t lane_credit,
  output logic               hdr_credit,
  output ppe_pkg::ppe_hdr_t  lane_hdr [`NUM_LANES]
);
  import ppe_pkg::*;

  localparam int qptr_w = $clog2(`DISP_DEPTH);
  localparam disp_cnt_t q_full = disp_cnt_t'(`DISP_DEPTH);
  localparam lane_cnt_t lane_full = lane_cnt_t'(`LANE_FIFO_DEPTH);

  // ----------------------------------------------------------------------
  // input queue
  // ----------------------------------------------------------------------
  ppe_hdr_t          q_mem [`DISP_DEPTH];
  logic [qptr_w-1:0] q_wr_ptr;
  logic [qptr_w-1:0] q_rd_ptr;
  disp_cnt_t         q_count;
  logic              enq;
  logic              issue;

  // per-lane credits and arbiter state
  lane_cnt_t         lane_cnt [`NUM_LANES];
  lane_idx_t         rr_ptr;
  lane_idx_t         sel_lane;
  logic              sel_found;

  // source only drives valid while it holds a credit
  assign enq   = hdr_in.valid;
  // head present and some lane can take it
  assign issue = (q_count != '0) && sel_found;

  always_ff @(posedge cclk) begin
    if (enq) begin
      q_mem[q_wr_ptr] <= hdr_in;
    end
  end

  always_ff @(posedge cclk) begin
    if (rst) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_count  <= '0;
    end else begin
      if (enq) begin
        q_wr_ptr <= (q_wr_ptr == qptr_w'(`DISP_DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
      end
      if (issue) begin
        q_rd_ptr <= (q_rd_ptr == qptr_w'(`DISP_DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
      end
      q_count <= q_count + disp_cnt_t'(enq) - disp_cnt_t'(issue);
    end
  end

  // ----------------------------------------------------------------------
  // round-robin pick among lanes holding credit
  // ----------------------------------------------------------------------
  always_comb begin
    lane_idx_t cand;
    sel_found = 1'b0;
    sel_lane  = rr_ptr;
    // scan starts at rr_ptr, first lane with credit wins
    for (int k = 0; k < `NUM_LANES; k++) begin
      cand = lane_idx_t'((int'(rr_ptr) + k) % `NUM_LANES);
      if (!sel_found && lane_cnt[cand] != '0) begin
        sel_found = 1'b1;
        sel_lane  = cand;
      end
    end
  end

  always_ff @(posedge cclk) begin
    if (rst) begin
      rr_ptr     <= '0;
      hdr_credit <= 1'b0;
      for (int i = 0; i < `NUM_LANES; i++) begin
        lane_cnt[i]       <= lane_full;
        lane_hdr[i].valid <= 1'b0;
      end
    end else begin
      // one queue slot freed per issue
      hdr_credit <= issue;
      if (issue) begin
        rr_ptr <= lane_idx_t'((int'(sel_lane) + 1) % `NUM_LANES);
      end
      for (int i = 0; i < `NUM_LANES; i++) begin
        // returned credit in, spent credit out
        lane_cnt[i] <= lane_cnt[i] + lane_cnt_t'(lane_credit[i])
                       - lane_cnt_t'(issue && (sel_lane == lane_idx_t'(i)));
        if (issue && (sel_lane == lane_idx_t'(i))) begin
          // queued entries already carry valid
          lane_hdr[i] <= q_mem[q_rd_ptr];
        end else begin
          lane_hdr[i].valid <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_cnt_chk
    // lane returns no more credits than it was given
    a_lane_cnt_max: assert property (@(posedge cclk) disable iff (rst)
      lane_cnt[i] <= lane_full);
  end

  // source must not send without a credit
  a_q_no_overflow: assert property (@(posedge cclk) disable iff (rst)
    enq |-> (q_count != q_full));

endmodule

// File: rtl/ppe_config.svh
// receive PPE parameters: lane count, pipeline depth, queue depths, field widths
`ifndef PPE_CONFIG_SVH
`define PPE_CONFIG_SVH

// ----------------------------------------------------------------------
// lane structure
// ----------------------------------------------------------------------
// parallel processing lanes
`define NUM_LANES 4
// registered stages per lane pipeline
`define PIPE_DEPTH 6

// ----------------------------------------------------------------------
// queue depths, each one also the starting credit of its upstream hop
// ----------------------------------------------------------------------
`define LANE_FIFO_DEPTH 2
`define MERGE_BUF_DEPTH 4
`define DISP_DEPTH 4
// sink credit ceiling
`define OUT_CREDITS 8

// ----------------------------------------------------------------------
// field widths
// ----------------------------------------------------------------------
`define ID_BITS 8
`define PORT_BITS 5
`define TC_BITS 3

`endif

// File: rtl/ppe_lane.sv
// processing lane: header FIFO, merger credit counter, classifier and delay pipeline
`timescale 1ns/1ps
`include "ppe_config.svh"

module ppe_lane (
  input  logic              cclk,
  input  logic              rst,
  input  ppe_pkg::ppe_hdr_t hdr_in,
  input  logic              merge_credit,
  output logic              hdr_credit,
  output ppe_pkg::ppe_res_t res_out
);
  import ppe_pkg::*;

  localparam int fptr_w = $clog2(`LANE_FIFO_DEPTH);
  localparam lane_cnt_t fifo_full = lane_cnt_t'(`LANE_FIFO_DEPTH);
  localparam merge_cnt_t mcred_init = merge_cnt_t'(`MERGE_BUF_DEPTH);

  // ----------------------------------------------------------------------
  // input FIFO
  // ----------------------------------------------------------------------
  ppe_hdr_t          fifo_mem [`LANE_FIFO_DEPTH];
  logic [fptr_w-1:0] fifo_wr_ptr;
  logic [fptr_w-1:0] fifo_rd_ptr;
  lane_cnt_t         fifo_count;
  ppe_hdr_t          head;
  logic              push;
  logic              pop;

  // merge buffer slots owned by this lane
  merge_cnt_t        mcred;

  // classifier output and delay line
  logic [7:0]        port_hash;
  ppe_res_t          cls;
  ppe_res_t          pipe [`PIPE_DEPTH];

  assign push = hdr_in.valid;
  assign head = fifo_mem[fifo_rd_ptr];
  // a slot downstream is reserved at pop, so the pipeline never stalls
  assign pop  = (fifo_count != '0) && (mcred != '0);

  always_ff @(posedge cclk) begin
    if (push) begin
      fifo_mem[fifo_wr_ptr] <= hdr_in;
    end
  end

  always_ff @(posedge cclk) begin
    if (rst) begin
      fifo_wr_ptr <= '0;
      fifo_rd_ptr <= '0;
      fifo_count  <= '0;
      mcred       <= mcred_init;
      hdr_credit  <= 1'b0;
    end else begin
      if (push) begin
        fifo_wr_ptr <= (fifo_wr_ptr == fptr_w'(`LANE_FIFO_DEPTH - 1)) ? '0
                       : fifo_wr_ptr + 1'b1;
      end
      if (pop) begin
        fifo_rd_ptr <= (fifo_rd_ptr == fptr_w'(`LANE_FIFO_DEPTH - 1)) ? '0
                       : fifo_rd_ptr + 1'b1;
      end
      fifo_count <= fifo_count + lane_cnt_t'(push) - lane_cnt_t'(pop);
      mcred      <= mcred + merge_cnt_t'(merge_credit) - merge_cnt_t'(pop);
      // FIFO slot back to dispatcher
      hdr_credit <= pop;
    end
  end

  // ----------------------------------------------------------------------
  // classification
  // ----------------------------------------------------------------------
  // port from low byte xor second byte of dmac
  assign port_hash = head.dmac[7:0] ^ head.dmac[15:8];

  always_comb begin
    cls             = '0;
    cls.valid       = pop;
    cls.id          = head.id;
    cls.port        = port_hash[`PORT_BITS-1:0];
    cls.tc          = head.pcp;
    cls.policer_idx = {head.in_port, head.pcp};
    // group bit is the lsb of the first octet
    cls.pkt_type    = pkt_type_t'({head.mirror, head.dmac[40]});
  end

  // ----------------------------------------------------------------------
  // fixed delay line, PIPE_DEPTH cycles from pop to res_out
  // ----------------------------------------------------------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      for (int s = 0; s < `PIPE_DEPTH; s++) begin
        pipe[s].valid <= 1'b0;
      end
    end else begin
      pipe[0] <= cls;
      for (int s = 1; s < `PIPE_DEPTH; s++) begin
        pipe[s] <= pipe[s-1];
      end
    end
  end

  assign res_out = pipe[`PIPE_DEPTH-1];

  // dispatcher must hold a credit for every push
  a_fifo_no_overflow: assert property (@(posedge cclk) disable iff (rst)
    push |-> (fifo_count != fifo_full));

endmodule

// File: rtl/ppe_pkg.sv
// receive PPE types: packet-type enum, header and result structs, credit widths
`include "ppe_config.svh"

package ppe_pkg;

  // ----------------------------------------------------------------------
  // packet type
  // ----------------------------------------------------------------------
  // encoding is {mirror, group bit}, so classification is a plain concat
  typedef enum logic [1:0] {
    uc        = 2'b00,
    mc        = 2'b01,
    mirror_uc = 2'b10,
    mirror_mc = 2'b11
  } pkt_type_t;

  // ----------------------------------------------------------------------
  // header segment from ingress
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                  valid;
    logic [`ID_BITS-1:0]   id;
    logic [`PORT_BITS-1:0] in_port;
    // first octet in bits 47:40, group bit at 40
    logic [47:0]           dmac;
    logic [`TC_BITS-1:0]   pcp;
    logic                  mirror;
  } ppe_hdr_t;

  // ----------------------------------------------------------------------
  // forwarding result back to ingress
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                            valid;
    logic [`ID_BITS-1:0]             id;
    // egress port
    logic [`PORT_BITS-1:0]           port;
    logic [`TC_BITS-1:0]             tc;
    // {in_port, tc}
    logic [`PORT_BITS+`TC_BITS-1:0]  policer_idx;
    pkt_type_t                       pkt_type;
  } ppe_res_t;

  // ----------------------------------------------------------------------
  // lane vectors and credit counters
  // ----------------------------------------------------------------------
  // one bit per lane
  typedef logic [`NUM_LANES-1:0] lane_vec_t;
  // lane number, also round-robin pointer
  typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

  // counters wide enough to hold their full value
  typedef logic [$clog2(`DISP_DEPTH+1)-1:0]      disp_cnt_t;
  typedef logic [$clog2(`LANE_FIFO_DEPTH+1)-1:0] lane_cnt_t;
  typedef logic [$clog2(`MERGE_BUF_DEPTH+1)-1:0] merge_cnt_t;
  typedef logic [$clog2(`OUT_CREDITS+1)-1:0]     out_cnt_t;

endpackage

// File: rtl/result_merge.sv
// result merger: per-lane buffers, round-robin output arbiter, output credit counter
`timescale 1ns/1ps
`include "ppe_config.svh"

module result_merge (
  input  logic               cclk,
  input  logic               rst,
  input  ppe_pkg::ppe_res_t  lane_res [`NUM_LANES],
  input  logic               res_credit,
  output ppe_pkg::lane_vec_t merge_credit,
  output ppe_pkg::ppe_res_t  res_out
);
  import ppe_pkg::*;

  localparam int bptr_w = $clog2(`MERGE_BUF_DEPTH);
  localparam merge_cnt_t rb_full = merge_cnt_t'(`MERGE_BUF_DEPTH);
  localparam out_cnt_t out_max = out_cnt_t'(`OUT_CREDITS);

  // ----------------------------------------------------------------------
  // per-lane result buffers
  // ----------------------------------------------------------------------
  ppe_res_t          rb_mem    [`NUM_LANES][`MERGE_BUF_DEPTH];
  logic [bptr_w-1:0] rb_wr_ptr [`NUM_LANES];
  logic [bptr_w-1:0] rb_rd_ptr [`NUM_LANES];
  merge_cnt_t        rb_count  [`NUM_LANES];

  // arbiter and sink credits
  lane_idx_t         rr_ptr;
  lane_idx_t         sel_lane;
  logic              sel_found;
  logic              send;
  out_cnt_t          out_cnt;
  out_cnt_t          out_cnt_nxt;

  always_ff @(posedge cclk) begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (lane_res[i].valid) begin
        rb_mem[i][rb_wr_ptr[i]] <= lane_res[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // round-robin over non-empty buffers
  // ----------------------------------------------------------------------
  always_comb begin
    lane_idx_t cand;
    sel_found = 1'b0;
    sel_lane  = rr_ptr;
    for (int k = 0; k < `NUM_LANES; k++) begin
      cand = lane_idx_t'((int'(rr_ptr) + k) % `NUM_LANES);
      if (!sel_found && rb_count[cand] != '0) begin
        sel_found = 1'b1;
        sel_lane  = cand;
      end
    end
  end

  // only with a sink credit in hand
  assign send = sel_found && (out_cnt != '0);

  // sink credit count, saturating at OUT_CREDITS
  always_comb begin
    out_cnt_nxt = out_cnt - out_cnt_t'(send);
    if (res_credit && out_cnt_nxt != out_max) begin
      out_cnt_nxt = out_cnt_nxt + 1'b1;
    end
  end

  always_ff @(posedge cclk) begin
    if (rst) begin
      rr_ptr        <= '0;
      out_cnt       <= '0;
      merge_credit  <= '0;
      res_out.valid <= 1'b0;
      for (int i = 0; i < `NUM_LANES; i++) begin
        rb_wr_ptr[i] <= '0;
        rb_rd_ptr[i] <= '0;
        rb_count[i]  <= '0;
      end
    end else begin
      out_cnt      <= out_cnt_nxt;
      merge_credit <= '0;
      if (send) begin
        // registered output, buffer slot handed back to the lane
        res_out                <= rb_mem[sel_lane][rb_rd_ptr[sel_lane]];
        merge_credit[sel_lane] <= 1'b1;
        rr_ptr                 <= lane_idx_t'((int'(sel_lane) + 1) % `NUM_LANES);
      end else begin
        res_out.valid <= 1'b0;
      end
      for (int i = 0; i < `NUM_LANES; i++) begin
        if (lane_res[i].valid) begin
          rb_wr_ptr[i] <= (rb_wr_ptr[i] == bptr_w'(`MERGE_BUF_DEPTH - 1)) ? '0
                          : rb_wr_ptr[i] + 1'b1;
        end
        if (send && sel_lane == lane_idx_t'(i)) begin
          rb_rd_ptr[i] <= (rb_rd_ptr[i] == bptr_w'(`MERGE_BUF_DEPTH - 1)) ? '0
                          : rb_rd_ptr[i] + 1'b1;
        end
        rb_count[i] <= rb_count[i] + merge_cnt_t'(lane_res[i].valid)
                       - merge_cnt_t'(send && sel_lane == lane_idx_t'(i));
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_rb_chk
    // lane spends a credit at pop, so a full buffer means lost credit
    a_rb_no_overflow: assert property (@(posedge cclk) disable iff (rst)
      lane_res[i].valid |-> (rb_count[i] != rb_full));
  end

  // every result was covered by a sink credit the cycle before
  a_out_has_credit: assert property (@(posedge cclk) disable iff (rst)
    res_out.valid |-> ($past(out_cnt) != '0));

endmodule

// File: rtl/rx_ppe_top.sv
// receive PPE top: dispatcher, generated processing lanes, result merger
`timescale 1ns/1ps
`include "ppe_config.svh"

module rx_ppe_top (
  input  logic              cclk,
  input  logic              rst,
  input  ppe_pkg::ppe_hdr_t hdr_in,
  input  logic              res_credit,
  output logic              hdr_credit,
  output ppe_pkg::ppe_res_t res_out
);
  import ppe_pkg::*;

  // ----------------------------------------------------------------------
  // inter-block wiring
  // ----------------------------------------------------------------------
  // dispatcher to lanes, credits back
  ppe_hdr_t  lane_hdr [`NUM_LANES];
  lane_vec_t lane_credit;
  // lanes to merger, credits back
  ppe_res_t  lane_res [`NUM_LANES];
  lane_vec_t merge_credit;

  hdr_dispatch u_dispatch (
    .cclk        (cclk),
    .rst         (rst),
    .hdr_in      (hdr_in),
    .lane_credit (lane_credit),
    .hdr_credit  (hdr_credit),
    .lane_hdr    (lane_hdr)
  );

  // one lane per slot
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    ppe_lane u_lane (
      .cclk         (cclk),
      .rst          (rst),
      .hdr_in       (lane_hdr[i]),
      .merge_credit (merge_credit[i]),
      .hdr_credit   (lane_credit[i]),
      .res_out      (lane_res[i])
    );
  end

  result_merge u_merge (
    .cclk         (cclk),
    .rst          (rst),
    .lane_res     (lane_res),
    .res_credit   (res_credit),
    .merge_credit (merge_credit),
    .res_out      (res_out)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the receive PPE testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rx_ppe \
  -f filelist.f \
  --Mdir obj_dir -o tb_rx_ppe_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/tb_rx_ppe_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/tb_rx_ppe.sv
// testbench for rx_ppe_top: test table, source and sink models, scoreboard, timeout
`timescale 1ns/1ps
`include "ppe_config.svh"

module tb_rx_ppe;
  import ppe_pkg::*;

  localparam int num_tests   = 7;
  localparam int min_lat     = 3 + `PIPE_DEPTH;
  localparam int hold_pulses = 3;
  localparam int id_space    = 2 ** `ID_BITS;

  // one row per test: stimulus shape and expected packet type
  typedef struct {
    string     name;
    int        n_hdr;
    bit        directed;
    bit        group;
    bit        mirror;
    bit        hold;
    pkt_type_t exp_type;
  } test_t;

  logic     cclk;
  logic     rst;
  ppe_hdr_t hdr_in;
  logic     res_credit;
  logic     hdr_credit;
  ppe_res_t res_out;

  test_t       tbl      [num_tests];
  // scoreboard, indexed by segment id
  ppe_res_t    want_tab [id_space];
  bit          pend     [id_space];
  int          sent_cyc [id_space];
  logic [31:0] lcg_state;

  int cycle;
  int limit;
  int next_id;
  int sent_total;
  int credit_total;
  int res_total;
  int matched_total;
  int given;
  int pulse_left;
  bit sink_open;
  int err_count;
  int pass_tests;
  int fail_tests;

  rx_ppe_top u_dut (
    .cclk       (cclk),
    .rst        (rst),
    .hdr_in     (hdr_in),
    .res_credit (res_credit),
    .hdr_credit (hdr_credit),
    .res_out    (res_out)
  );

  initial begin
    cclk = 1'b0;
    forever #4 cclk = ~cclk;
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected forwarding result for one header
  function automatic ppe_res_t expect_res(input ppe_hdr_t h);
    ppe_res_t   r;
    logic [7:0] mix;
    r             = '0;
    mix           = h.dmac[7:0] ^ h.dmac[15:8];
    r.valid       = 1'b1;
    r.id          = h.id;
    r.port        = mix[`PORT_BITS-1:0];
    r.tc          = h.pcp;
    r.policer_idx = {h.in_port, h.pcp};
    // group bit = lsb of first octet
    if (h.mirror) begin
      r.pkt_type = h.dmac[40] ? mirror_mc : mirror_uc;
    end else begin
      r.pkt_type = h.dmac[40] ? mc : uc;
    end
    return r;
  endfunction

  task automatic set_test(input int i, input string nm, input int n, input bit dir,
                          input bit g, input bit m, input bit hold, input pkt_type_t et);
    tbl[i].name     = nm;
    tbl[i].n_hdr    = n;
    tbl[i].directed = dir;
    tbl[i].group    = g;
    tbl[i].mirror   = m;
    tbl[i].hold     = hold;
    tbl[i].exp_type = et;
  endtask

  // random header, directed rows force group bit and mirror flag
  task automatic build_hdr(input int t, output ppe_hdr_t h);
    logic [31:0] r0;
    logic [31:0] r1;
    r0        = lcg_next();
    r1        = lcg_next();
    h         = '0;
    h.valid   = 1'b1;
    h.id      = next_id[`ID_BITS-1:0];
    h.dmac    = {r0, r1[15:0]};
    h.in_port = r1[16 +: `PORT_BITS];
    h.pcp     = r1[24 +: `TC_BITS];
    h.mirror  = r1[31];
    next_id   = next_id + 1;
    if (tbl[t].directed) begin
      h.dmac[40] = tbl[t].group;
      h.mirror   = tbl[t].mirror;
    end
    want_tab[h.id] = expect_res(h);
    if (tbl[t].directed) begin
      want_tab[h.id].pkt_type = tbl[t].exp_type;
    end
    pend[h.id] = 1'b1;
  endtask

  // one falling edge: clear header, drive sink credit
  task automatic tick();
    @(negedge cclk);
    hdr_in     = '0;
    res_credit = 1'b0;
    if (pulse_left > 0) begin
      res_credit = 1'b1;
      pulse_left = pulse_left - 1;
    end else if (sink_open && given < sent_total && given - res_total < `OUT_CREDITS) begin
      // one slot per result still expected, never past the saturation point
      res_credit = 1'b1;
    end
    if (res_credit) begin
      given = given + 1;
    end
  endtask

  // waits for a source credit
  task automatic send_hdr(input ppe_hdr_t h);
    tick();
    while (`DISP_DEPTH + credit_total - sent_total <= 0) begin
      tick();
    end
    hdr_in     = h;
    sent_total = sent_total + 1;
  endtask

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_res(input ppe_res_t got, input ppe_res_t want);
    if (got !== want) begin
      err_count = err_count + 1;
      $display("FAIL @%0t: id %0d got port %0d tc %0d pol %0d type %0d", $time,
               want.id, got.port, got.tc, got.policer_idx, got.pkt_type);
      $display("     expected port %0d tc %0d pol %0d type %0d",
               want.port, want.tc, want.policer_idx, want.pkt_type);
    end
  endtask

  task automatic check_count(input int got, input int want, input string what);
    if (got != want) begin
      err_count = err_count + 1;
      $display("FAIL @%0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic take_result(input ppe_res_t r);
    res_total = res_total + 1;
    if (!pend[r.id]) begin
      err_count = err_count + 1;
      $display("FAIL @%0t: result id %0d was not expected or came twice", $time, r.id);
    end else begin
      pend[r.id]    = 1'b0;
      matched_total = matched_total + 1;
      check_res(r, want_tab[r.id]);
      if (cycle - sent_cyc[r.id] < min_lat) begin
        err_count = err_count + 1;
        $display("FAIL @%0t: id %0d latency %0d below %0d", $time, r.id,
                 cycle - sent_cyc[r.id], min_lat);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // monitor and timeout
  // ----------------------------------------------------------------------
  always @(posedge cclk) begin
    cycle = cycle + 1;
    if (cycle >= limit) begin
      $display("run stopped: no progress after %0d cycles, results still missing", cycle);
      $display("*** TEST FAILED ***");
      $finish;
    end else if (!rst) begin
      if (hdr_in.valid) begin
        sent_cyc[hdr_in.id] = cycle;
      end
      if (hdr_credit) begin
        credit_total = credit_total + 1;
      end
      if (res_out.valid) begin
        take_result(res_out);
      end
    end
  end

  // ----------------------------------------------------------------------
  // test body
  // ----------------------------------------------------------------------
  task automatic run_test(input int t);
    ppe_hdr_t h;
    int       r0;
    int       c0;
    r0        = res_total;
    c0        = credit_total;
    sink_open = !tbl[t].hold;
    if (tbl[t].n_hdr == 0) begin
      repeat (40) tick();
      check_count(credit_total - c0, 0, "hdr_credit pulses while idle");
    end else begin
      for (int n = 0; n < tbl[t].n_hdr; n++) begin
        build_hdr(t, h);
        send_hdr(h);
      end
      if (tbl[t].hold) begin
        repeat (30) tick();
        check_count(res_total - r0, 0, "results while sink withholds credit");
        pulse_left = hold_pulses;
        repeat (30) tick();
        check_count(res_total - r0, hold_pulses, "results after credit pulses");
        // full release
        sink_open = 1'b1;
      end
      while (matched_total != sent_total) begin
        tick();
      end
    end
    check_count(res_total - r0, tbl[t].n_hdr, "results returned");
  endtask

  initial begin
    int e0;
    rst           = 1'b1;
    hdr_in        = '0;
    res_credit    = 1'b0;
    lcg_state     = 32'h4c38_770a;
    cycle         = 0;
    next_id       = 0;
    sent_total    = 0;
    credit_total  = 0;
    res_total     = 0;
    matched_total = 0;
    given         = 0;
    pulse_left    = 0;
    sink_open     = 1'b0;
    err_count     = 0;
    pass_tests    = 0;
    fail_tests    = 0;
    for (int i = 0; i < id_space; i++) begin
      pend[i] = 1'b0;
    end

    set_test(0, "idle after reset",   0,  1'b0, 1'b0, 1'b0, 1'b0, uc);
    set_test(1, "single unicast",     1,  1'b1, 1'b0, 1'b0, 1'b0, uc);
    set_test(2, "multicast",          1,  1'b1, 1'b1, 1'b0, 1'b0, mc);
    set_test(3, "mirrored unicast",   1,  1'b1, 1'b0, 1'b1, 1'b0, mirror_uc);
    set_test(4, "mirrored multicast", 1,  1'b1, 1'b1, 1'b1, 1'b0, mirror_mc);
    set_test(5, "random burst",       32, 1'b0, 1'b0, 1'b0, 1'b0, uc);
    set_test(6, "sink back-pressure", 16, 1'b0, 1'b0, 1'b0, 1'b1, uc);

    // cycle budget scales with header count
    limit = 200;
    for (int t = 0; t < num_tests; t++) begin
      limit = limit + tbl[t].n_hdr * (`PIPE_DEPTH + 20);
    end

    repeat (2) @(negedge cclk);
    rst = 1'b0;

    for (int t = 0; t < num_tests; t++) begin
      e0 = err_count;
      run_test(t);
      if (err_count == e0) begin
        pass_tests = pass_tests + 1;
        $display("test %0d %s: ok", t, tbl[t].name);
      end else begin
        fail_tests = fail_tests + 1;
        $display("test %0d %s: %0d errors", t, tbl[t].name, err_count - e0);
      end
    end

    // source back to its starting credit
    repeat (4) tick();
    e0 = err_count;
    check_count(`DISP_DEPTH + credit_total - sent_total, `DISP_DEPTH, "source credits at end");
    check_count(res_total, sent_total, "results against headers sent");
    if (err_count == e0) begin
      pass_tests = pass_tests + 1;
      $display("credit balance: ok");
    end else begin
      fail_tests = fail_tests + 1;
      $display("credit balance: %0d errors", err_count - e0);
    end

    $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (err_count == 0 && fail_tests == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
